// ==== rtl/synth_pkg.sv ====
package synth_pkg;

    localparam int sample_w = 8;          // Samples, settings, amplitude
    localparam int note_w = 6;            // Note code from the receiver
    localparam int div_w = 16;            // Note divisor width

    localparam int notes_per_octave = 12;
    localparam int note_count = 36;       // Three octaves

    // Lowest octave C to B, one step every divisor+1 cycles
    localparam logic [div_w-1:0] note_base [notes_per_octave] = '{
        16'd239,  // C
        16'd225,  // C sharp
        16'd213,  // D
        16'd201,  // D sharp
        16'd190,  // E
        16'd179,  // F
        16'd169,  // F sharp
        16'd159,  // G
        16'd150,  // G sharp
        16'd142,  // A
        16'd134,  // A sharp
        16'd127   // B
    };

    localparam logic [7:0] cmd_noise_on = 8'h4E;   // 'N'
    localparam logic [7:0] cmd_noise_off = 8'h46;  // 'F'
    localparam logic [7:0] cmd_tri = 8'h54;        // 'T'
    localparam logic [7:0] cmd_saw = 8'h53;        // 'S'
    localparam logic [7:0] cmd_square = 8'h51;     // 'Q'

    typedef enum logic [1:0] {
        wave_tri,
        wave_saw,
        wave_square
    } wave_t;

    typedef enum logic [2:0] {
        adsr_idle,
        adsr_attack,
        adsr_decay,
        adsr_sustain,
        adsr_release
    } adsr_state_t;

    localparam int hold_cycles = 256;               // Idle and sustain hold length
    localparam logic [15:0] lfsr_seed = 16'hACE1;
    localparam int frame_bits = 16;                 // Bits per I2S word

endpackage

// ==== rtl/command_rx.sv ====
`timescale 1ns/1ps

module command_rx import synth_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx,
    output logic [note_w-1:0] note,
    output wave_t             wave,
    output logic              noise_on
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_receive,
        rx_decode
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_last;
    logic [2:0] bit_cnt;
    logic [7:0] rx_byte;
    logic       start_edge;

    assign start_edge = rx_last & ~rx_sync;  // Falling edge on the synced line

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        rx_byte[bit_cnt] <= (state == rx_receive) ? rx_sync : rx_byte[bit_cnt];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rx_idle;
            bit_cnt <= 3'd0;
            note <= '0;
            wave <= wave_tri;
            noise_on <= 1'b0;
        end else begin
            case (state)
                rx_idle: begin
                    bit_cnt <= 3'd0;
                    if (start_edge) state <= rx_receive;
                end
                rx_receive: begin
                    bit_cnt <= bit_cnt + 3'd1;  // LSB first
                    if (bit_cnt == 3'd7) state <= rx_decode;
                end
                rx_decode: begin
                    case (rx_byte)
                        cmd_noise_on:  noise_on <= 1'b1;
                        cmd_noise_off: noise_on <= 1'b0;
                        cmd_tri:       wave <= wave_tri;
                        cmd_saw:       wave <= wave_saw;
                        cmd_square:    wave <= wave_square;
                        default: begin
                            if (rx_byte >= 8'h30 && rx_byte <= 8'h39) begin
                                note <= note_w'(rx_byte - 8'h30);  // Digits 0 to 9
                            end else if (rx_byte >= 8'h41 && rx_byte <= 8'h5A) begin
                                note <= note_w'(rx_byte - 8'h37);  // Letters 10 to 35
                            end
                        end
                    endcase
                    state <= rx_idle;
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

// ==== rtl/tone_source.sv ====
`timescale 1ns/1ps

module tone_source import synth_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ena,
    input  logic                noise_on,
    input  logic [note_w-1:0]   note,
    input  wave_t               wave,
    output logic [sample_w-1:0] tone
);

    logic [note_w-1:0]   note_sel;
    logic [note_w-1:0]   note_idx;
    logic [note_w-1:0]   octave;
    logic [div_w-1:0]    divisor;
    logic [div_w-1:0]    div_cnt;
    logic                step;
    logic [sample_w-1:0] tri_cnt;
    logic                tri_up;
    logic [sample_w-1:0] saw_cnt;
    logic                square_high;
    logic [sample_w-1:0] square_level;
    logic [15:0]         lfsr;

    // Codes past the table fall back to the lowest C
    assign note_sel = (note < note_w'(note_count)) ? note : '0;
    assign note_idx = note_sel % note_w'(notes_per_octave);
    assign octave = note_sel / note_w'(notes_per_octave);
    assign divisor = note_base[note_idx[3:0]] >> octave;  // Each octave halves it

    assign step = ena && (div_cnt == '0);
    assign square_level = {sample_w{square_high}};  // 0 or 255

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (ena) begin
            div_cnt <= step ? divisor : div_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tri_cnt <= '0;
            tri_up <= 1'b1;
            saw_cnt <= '0;
            square_high <= 1'b0;
        end else if (step) begin
            saw_cnt <= saw_cnt + 1'b1;
            square_high <= ~square_high;
            if (tri_up) begin
                if (tri_cnt != '1) tri_cnt <= tri_cnt + 1'b1;
                else tri_up <= 1'b0;  // Turn at the top
            end else begin
                if (tri_cnt != '0) tri_cnt <= tri_cnt - 1'b1;
                else tri_up <= 1'b1;
            end
        end
    end

    // Taps x16+x14+x13+x11
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= lfsr_seed;
        end else if (ena && noise_on) begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_comb begin
        if (noise_on) begin
            tone = lfsr[15:8];  // Noise overrides the wave
        end else begin
            case (wave)
                wave_saw:    tone = saw_cnt;
                wave_square: tone = square_level;
                default:     tone = tri_cnt;
            endcase
        end
    end

endmodule

// ==== rtl/quadrature_knob.sv ====
`timescale 1ns/1ps

module quadrature_knob import synth_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ena,
    input  logic                a,
    input  logic                b,
    output logic [sample_w-1:0] value
);

    logic a_prev;
    logic b_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_prev <= 1'b0;
            b_prev <= 1'b0;
            value <= '0;
        end else if (ena) begin
            a_prev <= a;
            b_prev <= b;
            case ({a, a_prev, b, b_prev})
                4'b1000, 4'b0111: value <= value + 1'b1;  // Forward, wraps
                4'b0010, 4'b1101: value <= value - 1'b1;  // Backward
                default: value <= value;
            endcase
        end
    end

endmodule

// ==== rtl/envelope_source.sv ====
`timescale 1ns/1ps

module envelope_source import synth_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ena,
    input  logic [3:0]          knob_a,
    input  logic [3:0]          knob_b,
    output logic [sample_w-1:0] amplitude
);

    logic [sample_w-1:0]            setting [4];  // Attack, decay, sustain, release
    logic [sample_w-1:0]            decay_step;
    logic [sample_w-1:0]            release_step;
    logic [$clog2(hold_cycles)-1:0] hold_cnt;
    logic                           hold_done;
    adsr_state_t                    state;

    for (genvar i = 0; i < 4; i++) begin : g_knob
        quadrature_knob u_knob (
            .clk   (clk),
            .rst_n (rst_n),
            .ena   (ena),
            .a     (knob_a[i]),
            .b     (knob_b[i]),
            .value (setting[i])
        );
    end

    // A zero rate still moves so the envelope cannot stall
    assign decay_step = (setting[1] == '0) ? sample_w'(1) : setting[1];
    assign release_step = (setting[3] == '0) ? sample_w'(1) : setting[3];
    assign hold_done = (hold_cnt == '1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= adsr_idle;
            hold_cnt <= '0;
            amplitude <= '0;
        end else if (ena) begin
            case (state)
                adsr_idle: begin
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_done) state <= adsr_attack;
                end
                adsr_attack: begin
                    if (amplitude < setting[0]) amplitude <= amplitude + 1'b1;
                    else state <= adsr_decay;
                end
                adsr_decay: begin
                    if (amplitude > setting[2]) begin
                        if (amplitude - setting[2] > decay_step) begin
                            amplitude <= amplitude - decay_step;
                        end else begin
                            amplitude <= setting[2];  // Stop at sustain
                        end
                    end else begin
                        state <= adsr_sustain;
                    end
                end
                adsr_sustain: begin
                    hold_cnt <= hold_cnt + 1'b1;  // Level stays where decay left it
                    if (hold_done) state <= adsr_release;
                end
                adsr_release: begin
                    if (amplitude != '0) begin
                        amplitude <= (amplitude > release_step) ? amplitude - release_step : '0;
                    end else begin
                        state <= adsr_idle;
                    end
                end
                default: state <= adsr_idle;
            endcase
        end
    end

endmodule

// ==== rtl/i2s_output.sv ====
`timescale 1ns/1ps

module i2s_output import synth_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ena,
    input  logic [sample_w-1:0] tone,
    input  logic [sample_w-1:0] amplitude,
    output logic                sck,
    output logic                ws,
    output logic                sd
);

    logic [2*sample_w-1:0]         product;
    logic [sample_w-1:0]           scaled;
    logic [frame_bits-1:0]         next_word;
    logic [frame_bits-1:0]         shift_word;
    logic [$clog2(frame_bits)-1:0] bit_cnt;
    logic                          word_end;

    assign product = tone * amplitude;
    assign next_word = {scaled, scaled};  // Byte sent twice per word
    assign word_end = (bit_cnt == '1);

    always_ff @(posedge clk) begin
        if (ena) scaled <= product[2*sample_w-1:sample_w];  // Upper byte of the product
    end

    // Everything below moves on the sck falling edge
    always_ff @(posedge clk) begin
        if (ena && sck) begin
            if (word_end) shift_word <= {next_word[frame_bits-2:0], 1'b0};
            else shift_word <= {shift_word[frame_bits-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck <= 1'b0;
            ws <= 1'b0;
            sd <= 1'b0;
            bit_cnt <= '1;  // First falling edge starts a word
        end else if (ena) begin
            sck <= ~sck;
            if (sck) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (word_end) begin
                    ws <= ~ws;  // Together with the MSB
                    sd <= next_word[frame_bits-1];
                end else begin
                    sd <= shift_word[frame_bits-1];
                end
            end
        end
    end

endmodule

// ==== rtl/synth_top.sv ====
`timescale 1ns/1ps

module synth_top import synth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ena,
    input  logic       rx,
    input  logic [3:0] knob_a,
    input  logic [3:0] knob_b,
    output logic       sck,
    output logic       ws,
    output logic       sd
);

    logic [note_w-1:0]   note;
    wave_t               wave;
    logic                noise_on;
    logic [sample_w-1:0] tone;
    logic [sample_w-1:0] amplitude;

    command_rx u_command_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .note     (note),
        .wave     (wave),
        .noise_on (noise_on)
    );

    tone_source u_tone_source (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .noise_on (noise_on),
        .note     (note),
        .wave     (wave),
        .tone     (tone)
    );

    envelope_source u_envelope_source (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .knob_a    (knob_a),
        .knob_b    (knob_b),
        .amplitude (amplitude)
    );

    i2s_output u_i2s_output (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .tone      (tone),
        .amplitude (amplitude),
        .sck       (sck),
        .ws        (ws),
        .sd        (sd)
    );

endmodule

// ==== test/synth_sva.sv ====
`timescale 1ns/1ps

module synth_sva import synth_pkg::*; (
    input logic                clk,
    input logic                rst_n,
    input wave_t               wave,
    input logic                noise_on,
    input logic [sample_w-1:0] tone,
    input logic                sck,
    input logic                ws
);

    // Square output is either rail
    assert property (@(posedge clk) disable iff (!rst_n)
        (wave == wave_square && !noise_on) |-> (tone == 8'h00 || tone == 8'hFF))
        else $error("square tone %0d is not 0 or 255", tone);

    assert property (@(posedge clk) disable iff (!rst_n) $changed(ws) |-> !sck)
        else $error("ws changed while sck was high");

    assert property (@(posedge clk) !rst_n |=> !sck)
        else $error("sck high after a reset cycle");

endmodule

// Unused ports are tied off in each target
bind tone_source synth_sva u_tone_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .wave     (wave),
    .noise_on (noise_on),
    .tone     (tone),
    .sck      (1'b0),
    .ws       (1'b0)
);

bind i2s_output synth_sva u_i2s_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .wave     (wave_tri),
    .noise_on (1'b0),
    .tone     (tone),
    .sck      (sck),
    .ws       (ws)
);

// ==== test/synth_checker.sv ====
`timescale 1ns/1ps

module synth_checker import synth_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         sck,
    input  logic         ws,
    input  logic         sd,
    input  logic         case_active,
    input  logic [1:0]   case_class,  // 0 zero, 1 bounded, 2 noise, 3 repeat
    input  logic [7:0]   bound,
    input  logic [127:0] case_name,
    output int           word_count,
    output int           pass_count,
    output int           fail_count
);

    localparam int stall_limit = 64;  // Words start every 32 cycles

    logic        active_q;
    logic        ws_seen;
    logic [15:0] shift;
    int          bit_cnt;
    int          errors;
    int          stall;
    logic        stall_reported;
    logic        any_nonzero;
    logic        varied;
    logic        first_seen;
    logic [7:0]  first_byte;

    task automatic check_word(input logic [15:0] w);
        if (w[15:8] != w[7:0]) begin
            $display("[FAIL] %0t case %0s: word %h has unequal halves", $time, case_name, w);
            errors++;
        end
        if (case_class == 2'd0 && w != 16'd0) begin
            $display("[FAIL] %0t case %0s: word %h where silence expected", $time, case_name, w);
            errors++;
        end
        if ((case_class == 2'd1 || case_class == 2'd3) && w[15:8] > bound) begin
            $display("[FAIL] %0t case %0s: byte %0d above attack %0d",
                     $time, case_name, w[15:8], bound);
            errors++;
        end
        if (w != 16'd0) any_nonzero = 1'b1;
        if (first_seen && w[15:8] != first_byte) varied = 1'b1;
        if (!first_seen) begin
            first_byte = w[15:8];
            first_seen = 1'b1;
        end
    endtask

    task automatic finish_case();
        if (case_class == 2'd3 && !any_nonzero) begin
            $display("[FAIL] %0t case %0s: every word was zero", $time, case_name);
            errors++;
        end
        if (case_class == 2'd2 && !varied) begin
            $display("[FAIL] %0t case %0s: noise bytes never changed", $time, case_name);
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
            $display("Case %0s: pass, %0d words", case_name, word_count);
        end else begin
            fail_count++;
            $display("Case %0s: fail, %0d errors in %0d words", case_name, errors, word_count);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            active_q = 1'b0;
            ws_seen = 1'b0;  // Matches ws after reset
            shift = '0;
            bit_cnt = 0;
            stall = 0;
            word_count = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (case_active && !active_q) begin
                word_count = 0;
                errors = 0;
                stall = 0;
                stall_reported = 1'b0;
                any_nonzero = 1'b0;
                varied = 1'b0;
                first_seen = 1'b0;
            end
            if (sck) begin  // High phase, sd is stable
                if (ws != ws_seen) begin
                    ws_seen = ws;  // New word starts with its MSB
                    shift = {15'd0, sd};
                    bit_cnt = 1;
                    stall = 0;
                end else begin
                    shift = {shift[14:0], sd};
                    bit_cnt++;
                end
                if (bit_cnt == frame_bits && case_active) begin
                    check_word(shift);
                    word_count++;
                end
            end
            if (case_active) begin
                stall++;
                if (stall > stall_limit && !stall_reported) begin
                    $display("Case %0s: no I2S word start seen within %0d cycles",
                             case_name, stall_limit);
                    errors++;
                    stall_reported = 1'b1;
                end
            end
            if (!case_active && active_q) finish_case();
            active_q = case_active;
        end
    end

endmodule

// ==== test/synth_tb.sv ====
`timescale 1ns/1ps

module synth_tb import synth_pkg::*; ();

    localparam int max_cases = 32;
    localparam int step_delay = 1;  // Inputs change 1 ns after the edge

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic       rx;
    logic [3:0] knob_a;
    logic [3:0] knob_b;
    logic       sck;
    logic       ws;
    logic       sd;

    logic         case_active;
    logic [1:0]   case_class;
    logic [7:0]   bound;
    logic [127:0] case_name;
    int           word_count;
    int           pass_count;
    int           fail_count;

    logic [127:0] names [max_cases];
    logic [7:0]   cmds [max_cases];
    int           knob_moves [max_cases][4];
    int           frames [max_cases];
    logic [1:0]   classes [max_cases];

    int num_cases;
    int bad_lines;
    int cycle_count;
    int cycle_limit;
    int seed;
    int attack_total;

    synth_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .ena    (ena),
        .rx     (rx),
        .knob_a (knob_a),
        .knob_b (knob_b),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

    synth_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck         (sck),
        .ws          (ws),
        .sd          (sd),
        .case_active (case_active),
        .case_class  (case_class),
        .bound       (bound),
        .case_name   (case_name),
        .word_count  (word_count),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #step_delay;
    endtask

    // Start bit, then 8 data bits LSB first, then idle high
    task automatic send_byte(input logic [7:0] data);
        rx = 1'b0;
        next_cycle();
        for (int i = 0; i < 8; i++) begin
            rx = data[i];
            next_cycle();
        end
        rx = 1'b1;
        repeat (4) next_cycle();  // Let the decode settle
    endtask

    // Each forward cycle walks 10, 11, 01, 00 and adds 2
    task automatic turn_knob(input int idx, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            knob_a[idx] = 1'b1;
            knob_b[idx] = 1'b0;
            next_cycle();
            knob_b[idx] = 1'b1;
            next_cycle();
            knob_a[idx] = 1'b0;
            next_cycle();
            knob_b[idx] = 1'b0;
            next_cycle();
        end
    endtask

    function automatic logic [1:0] class_code(input logic [127:0] text, output logic ok);
        ok = 1'b1;
        if (text == "zero") return 2'd0;
        if (text == "bounded") return 2'd1;
        if (text == "noise") return 2'd2;
        if (text == "repeat") return 2'd3;
        ok = 1'b0;
        return 2'd0;
    endfunction

    task automatic read_cases();
        int           fd;
        int           got;
        string        line;
        logic [127:0] nm;
        logic [127:0] cls;
        logic [7:0]   cmd;
        int           k0;
        int           k1;
        int           k2;
        int           k3;
        int           fr;
        logic         ok;
        fd = $fopen("test/synth_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/synth_cases.txt");
            bad_lines++;
            return;
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 1 && line[0] != 8'h23 && num_cases < max_cases) begin  // Skip # lines
                got = $sscanf(line, "%s %h %d %d %d %d %d %s", nm, cmd, k0, k1, k2, k3, fr, cls);
                if (got == 8) begin
                    names[num_cases] = nm;
                    cmds[num_cases] = cmd;
                    knob_moves[num_cases][0] = k0;
                    knob_moves[num_cases][1] = k1;
                    knob_moves[num_cases][2] = k2;
                    knob_moves[num_cases][3] = k3;
                    frames[num_cases] = fr;
                    classes[num_cases] = class_code(cls, ok);
                    if (!ok) begin
                        $display("Unknown expected class in case %0s", nm);
                        bad_lines++;
                    end
                    num_cases++;
                end else begin
                    $display("Case file line could not be parsed: %s", line);
                    bad_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int idx);
        int gap;
        if (cmds[idx] != 8'hFF) send_byte(cmds[idx]);
        for (int k = 0; k < 4; k++) turn_knob(k, knob_moves[idx][k]);
        attack_total += knob_moves[idx][0];
        bound = (2 * attack_total > 255) ? 8'hFF : 8'(2 * attack_total);  // Attack setting
        case_class = classes[idx];
        case_name = names[idx];
        case_active = 1'b1;
        next_cycle();
        next_cycle();  // Checker clears its count first
        while (word_count < frames[idx]) next_cycle();
        case_active = 1'b0;
        repeat (2) next_cycle();
        gap = 1 + ($random(seed) & 7);  // Idle gap between cases
        repeat (gap) next_cycle();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        ena = 1'b0;
        rx = 1'b1;
        knob_a = 4'd0;
        knob_b = 4'd0;
        case_active = 1'b0;
        case_class = 2'd0;
        bound = 8'd0;
        case_name = '0;
        num_cases = 0;
        bad_lines = 0;
        cycle_count = 0;
        cycle_limit = 0;
        seed = 32'hf531;
        attack_total = 0;

        read_cases();
        for (int i = 0; i < num_cases; i++) cycle_limit += frames[i] * 32 + 400;
        if (cycle_limit == 0) cycle_limit = 400;

        repeat (2) next_cycle();  // Reset for 2 cycles
        rst_n = 1'b1;
        ena = 1'b1;

        for (int i = 0; i < num_cases; i++) run_case(i);

        $display("Cases run %0d, passed %0d, failed %0d, file errors %0d",
                 num_cases, pass_count, fail_count, bad_lines);
        if (bad_lines == 0 && fail_count == 0 && num_cases > 0 && pass_count == num_cases) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/synth_cases.txt ====
# name command(hex, FF none) attack decay sustain release (forward cycles) frames class
# class: zero, bounded, noise, repeat (repeat also needs one nonzero word)
silence FF 0 0 0 0 12 zero
triangle 54 3 0 0 0 30 bounded
saw 53 2 1 2 0 30 bounded
square 51 5 1 4 1 40 repeat
noise_on 4E 10 0 2 0 40 noise
noise_off 46 0 0 0 0 20 bounded
digit 35 0 0 0 0 20 bounded
letter 4B 1 0 0 0 20 bounded
unknown 7E 0 0 0 0 20 bounded
square_z 51 0 0 0 0 40 repeat
saw_low 53 0 2 0 3 20 bounded

// ==== project.f ====
rtl/synth_pkg.sv
rtl/command_rx.sv
rtl/tone_source.sv
rtl/quadrature_knob.sv
rtl/envelope_source.sv
rtl/i2s_output.sv
rtl/synth_top.sv
test/synth_sva.sv
test/synth_checker.sv
test/synth_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = synth_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
